//--- design/issue_pkg.sv
package issue_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Functional unit encoding, unit_none is the idle code
    typedef enum logic [1:0] {
        unit_alu  = 2'b00,
        unit_mem  = 2'b01,
        unit_mul  = 2'b10,
        unit_none = 2'b11
    } unit_e;

    localparam int num_units = 3;

    // Cycles from acceptance to the end of the write-back cycle
    localparam int unit_latency [num_units] = '{1, 2, 4};

    // Length of the write-back slot reservation vector
    localparam int max_latency = 4;

    // Opcodes and funct codes used for unit selection
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;
    localparam logic [5:0] funct_mult = 6'b011000;

endpackage

//--- design/unit_if.sv
interface unit_if import issue_pkg::*; ();

    // One operation moving between issue, a unit pipe and write-back
    logic      valid;
    reg_addr_t dest;
    logic      write_reg;
    word_t     data;

    modport source (
        output valid,
        output dest,
        output write_reg,
        output data
    );

    modport sink (
        input valid,
        input dest,
        input write_reg,
        input data
    );

endinterface

//--- design/scoreboard.sv
module scoreboard import issue_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    // Marked at issue
    input  logic      set_en,
    input  reg_addr_t set_addr,
    input  unit_e     set_unit,

    // Cleared at write-back
    input  logic      clr_en,
    input  reg_addr_t clr_addr,

    // Concurrent look-ups for src a, src b and dest
    input  reg_addr_t look_a,
    input  reg_addr_t look_b,
    input  reg_addr_t look_d,
    output logic      pend_a,
    output logic      pend_b,
    output logic      pend_d
);

    // Unit that will write each register, unit_none when nothing is in flight
    unit_e owner [32];

    logic [31:0] pending;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                owner[i] <= unit_none;
            end
        end else begin
            // Register 0 is never written, so its entry stays idle
            owner[0] <= unit_none;
            for (int i = 1; i < 32; i++) begin
                // Set wins over a clear to the same address
                if (set_en && set_addr == reg_addr_t'(i)) begin
                    owner[i] <= set_unit;
                end else if (clr_en && clr_addr == reg_addr_t'(i)) begin
                    owner[i] <= unit_none;
                end
            end
        end
    end

    // A register is pending while some unit owns it
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            pending[i] = (owner[i] != unit_none);
        end
    end

    assign pend_a = pending[look_a];
    assign pend_b = pending[look_b];
    assign pend_d = pending[look_d];

endmodule

//--- design/issue_stage.sv
module issue_stage import issue_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    // Decoded instruction from decode
    input  logic      id_valid,
    input  logic      id_use_b,
    input  logic      id_write_reg,
    input  logic [5:0] id_op,
    input  logic [5:0] id_funct,
    input  reg_addr_t id_addr_a,
    input  reg_addr_t id_addr_b,
    input  reg_addr_t id_dest,

    // Register file read port
    output reg_addr_t reg_addr_a,
    output reg_addr_t reg_addr_b,
    input  word_t     reg_data_a,
    input  word_t     reg_data_b,

    // Scoreboard
    input  logic      pend_a,
    input  logic      pend_b,
    input  logic      pend_d,
    output logic      set_en,
    output reg_addr_t set_addr,
    output unit_e     set_unit,

    output logic      id_stall,

    // Registered issue outputs
    output logic      iss_valid,
    output logic      iss_alu,
    output logic      iss_mem,
    output logic      iss_mul,
    output reg_addr_t iss_dest,
    output word_t     iss_rega,
    output word_t     iss_regb,

    unit_if.source    units [num_units]
);

    unit_e                  cls;
    int                     lat;
    logic                   accept;
    logic                   slot_busy;
    logic [max_latency-1:0] slot_res;
    logic [max_latency-1:0] slot_mask;
    unit_e                  unit_q;
    logic                   write_reg_q;

    // Unit selection from opcode and funct
    always_comb begin
        if (id_op == op_lw || id_op == op_sw) begin
            cls = unit_mem;
        end else if (id_op == op_special && id_funct == funct_mult) begin
            cls = unit_mul;
        end else begin
            cls = unit_alu;
        end
        lat = unit_latency[cls];
    end

    assign reg_addr_a = id_addr_a;
    assign reg_addr_b = id_addr_b;

    // Bit i set means the write-back cycle ending i+1 edges from now is taken
    assign slot_busy = slot_res[lat-1];

    assign id_stall = id_valid && (pend_a
                                   || (id_use_b && pend_b)
                                   || (id_write_reg && id_dest != '0 && pend_d)
                                   || slot_busy);

    assign accept    = id_valid && !id_stall;
    assign slot_mask = accept ? (max_latency'(1) << (lat - 1)) : '0;

    assign set_en   = accept && id_write_reg && id_dest != '0;
    assign set_addr = id_dest;
    assign set_unit = cls;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            slot_res  <= '0;
            iss_valid <= 1'b0;
            unit_q    <= unit_none;
        end else begin
            slot_res  <= (slot_res | slot_mask) >> 1;
            iss_valid <= accept;
            unit_q    <= accept ? cls : unit_none;
        end
    end

    // Operands and dest are held until the next issue
    always_ff @(posedge clock) begin
        if (accept) begin
            iss_dest    <= id_dest;
            iss_rega    <= reg_data_a;
            iss_regb    <= reg_data_b;
            write_reg_q <= id_write_reg;
        end
    end

    assign iss_alu = (unit_q == unit_alu);
    assign iss_mem = (unit_q == unit_mem);
    assign iss_mul = (unit_q == unit_mul);

    // Fire the chosen unit, all units see the same payload
    for (genvar g = 0; g < num_units; g++) begin : g_units
        assign units[g].valid     = (unit_q == unit_e'(g));
        assign units[g].dest      = iss_dest;
        assign units[g].write_reg = write_reg_q;
        assign units[g].data      = iss_rega;
    end

endmodule

//--- design/unit_pipe.sv
module unit_pipe import issue_pkg::*; #(
    parameter int LATENCY = 1
) (
    input  logic   clock,
    input  logic   reset,
    unit_if.sink   in_op,
    unit_if.source out_op
);

    if (LATENCY == 0) begin : g_direct
        // Single-cycle unit with the arbiter register as its only stage
        assign out_op.valid     = in_op.valid;
        assign out_op.dest      = in_op.dest;
        assign out_op.write_reg = in_op.write_reg;
        assign out_op.data      = in_op.data;
    end else begin : g_chain
        logic [LATENCY-1:0] stage_valid;
        reg_addr_t          stage_dest [LATENCY];
        logic [LATENCY-1:0] stage_write;
        word_t              stage_data [LATENCY];

        always_ff @(posedge clock or negedge reset) begin
            if (!reset) begin
                stage_valid <= '0;
            end else begin
                stage_valid <= LATENCY'({stage_valid, in_op.valid});
            end
        end

        // Payload shifts alongside valid
        always_ff @(posedge clock) begin
            stage_dest[0]  <= in_op.dest;
            stage_write[0] <= in_op.write_reg;
            stage_data[0]  <= in_op.data;
            for (int i = 1; i < LATENCY; i++) begin
                stage_dest[i]  <= stage_dest[i-1];
                stage_write[i] <= stage_write[i-1];
                stage_data[i]  <= stage_data[i-1];
            end
        end

        assign out_op.valid     = stage_valid[LATENCY-1];
        assign out_op.dest      = stage_dest[LATENCY-1];
        assign out_op.write_reg = stage_write[LATENCY-1];
        assign out_op.data      = stage_data[LATENCY-1];
    end

endmodule

//--- design/writeback_arbiter.sv
module writeback_arbiter import issue_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    unit_if.sink      done [num_units],

    output logic      wb_valid,
    output reg_addr_t wb_dest,
    output word_t     wb_data,
    output logic      clr_en,
    output reg_addr_t clr_addr
);

    logic [num_units-1:0] done_valid;
    logic [num_units-1:0] done_write;
    reg_addr_t            done_dest [num_units];
    word_t                done_data [num_units];

    logic      sel_valid;
    logic      sel_write;
    reg_addr_t sel_dest;
    word_t     sel_data;

    for (genvar g = 0; g < num_units; g++) begin : g_done
        assign done_valid[g] = done[g].valid;
        assign done_write[g] = done[g].write_reg;
        assign done_dest[g]  = done[g].dest;
        assign done_data[g]  = done[g].data;
    end

    // Slot reservation leaves at most one valid completion, so an OR merge is enough
    always_comb begin
        sel_valid = 1'b0;
        sel_write = 1'b0;
        sel_dest  = '0;
        sel_data  = '0;
        for (int i = 0; i < num_units; i++) begin
            sel_valid = sel_valid | done_valid[i];
            sel_write = sel_write | (done_valid[i] & done_write[i]);
            sel_dest  = sel_dest | (done_valid[i] ? done_dest[i] : '0);
            sel_data  = sel_data | (done_valid[i] ? done_data[i] : '0);
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wb_valid <= 1'b0;
        end else begin
            // Stores finish without a register write
            wb_valid <= sel_valid && sel_write;
        end
    end

    always_ff @(posedge clock) begin
        if (sel_valid) begin
            wb_dest <= sel_dest;
            wb_data <= sel_data;
        end
    end

    // Scoreboard clears at the edge that ends the write-back cycle
    assign clr_en   = wb_valid;
    assign clr_addr = wb_dest;

endmodule

//--- design/issue_top.sv
module issue_top import issue_pkg::*; (
    input  logic       clock,
    input  logic       reset,

    input  logic       id_valid,
    input  logic       id_use_b,
    input  logic       id_write_reg,
    input  logic [5:0] id_op,
    input  logic [5:0] id_funct,
    input  reg_addr_t  id_addr_a,
    input  reg_addr_t  id_addr_b,
    input  reg_addr_t  id_dest,
    output logic       id_stall,

    output reg_addr_t  reg_addr_a,
    output reg_addr_t  reg_addr_b,
    input  word_t      reg_data_a,
    input  word_t      reg_data_b,

    output logic       iss_valid,
    output logic       iss_alu,
    output logic       iss_mem,
    output logic       iss_mul,
    output reg_addr_t  iss_dest,
    output word_t      iss_rega,
    output word_t      iss_regb,

    output logic       wb_valid,
    output reg_addr_t  wb_dest,
    output word_t      wb_data
);

    logic      set_en;
    reg_addr_t set_addr;
    unit_e     set_unit;
    logic      clr_en;
    reg_addr_t clr_addr;
    logic      pend_a;
    logic      pend_b;
    logic      pend_d;

    // Issue side and completion side of each unit pipe
    unit_if iss_ops [num_units] ();
    unit_if done_ops [num_units] ();

    issue_stage u_issue (
        .clock        (clock),
        .reset        (reset),
        .id_valid     (id_valid),
        .id_use_b     (id_use_b),
        .id_write_reg (id_write_reg),
        .id_op        (id_op),
        .id_funct     (id_funct),
        .id_addr_a    (id_addr_a),
        .id_addr_b    (id_addr_b),
        .id_dest      (id_dest),
        .reg_addr_a   (reg_addr_a),
        .reg_addr_b   (reg_addr_b),
        .reg_data_a   (reg_data_a),
        .reg_data_b   (reg_data_b),
        .pend_a       (pend_a),
        .pend_b       (pend_b),
        .pend_d       (pend_d),
        .set_en       (set_en),
        .set_addr     (set_addr),
        .set_unit     (set_unit),
        .id_stall     (id_stall),
        .iss_valid    (iss_valid),
        .iss_alu      (iss_alu),
        .iss_mem      (iss_mem),
        .iss_mul      (iss_mul),
        .iss_dest     (iss_dest),
        .iss_rega     (iss_rega),
        .iss_regb     (iss_regb),
        .units        (iss_ops)
    );

    scoreboard u_scoreboard (
        .clock    (clock),
        .reset    (reset),
        .set_en   (set_en),
        .set_addr (set_addr),
        .set_unit (set_unit),
        .clr_en   (clr_en),
        .clr_addr (clr_addr),
        .look_a   (id_addr_a),
        .look_b   (id_addr_b),
        .look_d   (id_dest),
        .pend_a   (pend_a),
        .pend_b   (pend_b),
        .pend_d   (pend_d)
    );

    // The arbiter register supplies the last cycle of each unit's latency
    for (genvar g = 0; g < num_units; g++) begin : g_pipe
        unit_pipe #(
            .LATENCY (unit_latency[g] - 1)
        ) u_pipe (
            .clock  (clock),
            .reset  (reset),
            .in_op  (iss_ops[g]),
            .out_op (done_ops[g])
        );
    end

    writeback_arbiter u_arbiter (
        .clock    (clock),
        .reset    (reset),
        .done     (done_ops),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data),
        .clr_en   (clr_en),
        .clr_addr (clr_addr)
    );

endmodule

//--- tests/issue_props.sv
module issue_props (
    input logic clock,
    input logic reset,
    input logic id_valid,
    input logic id_stall,
    input logic iss_valid,
    input logic iss_alu,
    input logic iss_mem,
    input logic iss_mul
);

    logic [2:0] sel;

    assign sel = {iss_alu, iss_mem, iss_mul};

    // Never two units at once
    sel_onehot0: assert property (@(posedge clock) disable iff (!reset) $onehot0(sel))
        else $error("more than one unit select is high");

    valid_one_unit: assert property (@(posedge clock) disable iff (!reset)
        iss_valid |-> $onehot(sel))
        else $error("issue without exactly one unit select");

    // A stalled instruction must not reach the issue register
    stall_blocks_issue: assert property (@(posedge clock) disable iff (!reset)
        (id_valid && id_stall) |=> !iss_valid)
        else $error("issue followed a stalled cycle");

    reset_idle: assert property (@(posedge clock) !reset |=> (!iss_valid && sel == 3'b000))
        else $error("issue outputs active after reset");

endmodule

bind issue_stage issue_props u_props (
    .clock     (clock),
    .reset     (reset),
    .id_valid  (id_valid),
    .id_stall  (id_stall),
    .iss_valid (iss_valid),
    .iss_alu   (iss_alu),
    .iss_mem   (iss_mem),
    .iss_mul   (iss_mul)
);

//--- tests/issue_tb.sv
module issue_tb import issue_pkg::*; ();

    localparam int fields      = 11;
    localparam int max_cases   = 32;
    localparam int accept_wait = 20;
    localparam int drain_wait  = 20;

    logic       clock;
    logic       reset;
    logic       id_valid;
    logic       id_use_b;
    logic       id_write_reg;
    logic [5:0] id_op;
    logic [5:0] id_funct;
    reg_addr_t  id_addr_a;
    reg_addr_t  id_addr_b;
    reg_addr_t  id_dest;
    logic       id_stall;
    reg_addr_t  reg_addr_a;
    reg_addr_t  reg_addr_b;
    word_t      reg_data_a;
    word_t      reg_data_b;
    logic       iss_valid;
    logic       iss_alu;
    logic       iss_mem;
    logic       iss_mul;
    reg_addr_t  iss_dest;
    word_t      iss_rega;
    word_t      iss_regb;
    logic       wb_valid;
    reg_addr_t  wb_dest;
    word_t      wb_data;

    // Columns per case are gap op funct a b dest use_b wr unit wb_data tag
    logic [31:0] case_mem [fields*max_cases];

    int    cycle_count;
    int    checks;
    int    errors;
    int    wb_seen;
    int    wb_expected;
    int    outstanding;
    logic  aborted;
    int    pend_count [32];
    int    last_wb [32];
    int    due_cycle [32];
    word_t exp_data [32];

    issue_top dut (.*);

    // Register file model returns a fixed base plus the address
    assign reg_data_a = 32'h1000_0000 + 32'(reg_addr_a);
    assign reg_data_b = 32'h1000_0000 + 32'(reg_addr_b);

    always #5 clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR time %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("time %0t: %s", $time, msg);
    endtask

    // Cycles from issue to the write-back pulse for each unit
    function automatic int wb_latency(input int unit);
        case (unit)
            0:       return 1;
            1:       return 2;
            default: return 4;
        endcase
    endfunction

    // Advance to the next falling edge and account for a write-back in that cycle
    task automatic next_cycle();
        reg_addr_t d;
        @(negedge clock);
        cycle_count++;
        if (wb_valid) begin
            d = wb_dest;
            wb_seen++;
            if (pend_count[d] == 0) begin
                report_failure($sformatf("write-back to register %0d that nothing issued", d));
            end else begin
                check_value("wb_data", wb_data, exp_data[d]);
                check_value("wb_valid cycle", cycle_count, due_cycle[d]);
                pend_count[d]--;
                outstanding--;
            end
            last_wb[d] = cycle_count;
        end
    endtask

    // No bypass, so a register is usable two cycles after its write-back is seen
    task automatic check_hazard(input int idx, input reg_addr_t r);
        if (r != 0) begin
            if (pend_count[r] != 0) begin
                report_failure($sformatf("case %0d issued while register %0d was pending",
                                         idx, r));
            end else if (last_wb[r] >= 0 && cycle_count < last_wb[r] + 2) begin
                report_failure($sformatf("case %0d issued before register %0d was cleared",
                                         idx, r));
            end
        end
    endtask

    task automatic run_case(input int k);
        int   base;
        int   unit;
        int   tag;
        int   stalls;
        int   waited;
        int   errors_before;
        logic accepted;
        base          = k * fields;
        unit          = case_mem[base + 8];
        tag           = case_mem[base + 10];
        errors_before = errors;
        for (int i = 0; i < case_mem[base]; i++) begin
            next_cycle();
        end
        id_valid     = 1'b1;
        id_op        = case_mem[base + 1][5:0];
        id_funct     = case_mem[base + 2][5:0];
        id_addr_a    = case_mem[base + 3][4:0];
        id_addr_b    = case_mem[base + 4][4:0];
        id_dest      = case_mem[base + 5][4:0];
        id_use_b     = case_mem[base + 6][0];
        id_write_reg = case_mem[base + 7][0];
        stalls   = 0;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < accept_wait) begin
            #1;
            if (id_stall) begin
                stalls++;
            end
            next_cycle();
            waited++;
            accepted = iss_valid;
        end
        id_valid = 1'b0;
        if (!accepted) begin
            report_failure($sformatf("case %0d was not issued within %0d cycles", k, accept_wait));
            aborted = 1'b1;
        end else begin
            check_value("iss_alu", iss_alu, unit == 0);
            check_value("iss_mem", iss_mem, unit == 1);
            check_value("iss_mul", iss_mul, unit == 2);
            check_value("iss_dest", iss_dest, id_dest);
            check_value("iss_rega", iss_rega, case_mem[base + 9]);
            check_value("iss_regb", iss_regb, 32'h1000_0000 + 32'(id_addr_b));
            check_hazard(k, id_addr_a);
            if (id_use_b) begin
                check_hazard(k, id_addr_b);
            end
            if (id_write_reg) begin
                check_hazard(k, id_dest);
                exp_data[id_dest]  = case_mem[base + 9];
                due_cycle[id_dest] = cycle_count + wb_latency(unit);
                pend_count[id_dest]++;
                outstanding++;
                wb_expected++;
            end
            if (tag != 0 && stalls == 0) begin
                report_failure($sformatf("case %0d was expected to stall and did not", k));
            end else if (tag == 0 && stalls != 0) begin
                report_failure($sformatf("case %0d stalled with no hazard", k));
            end
        end
        $display("case %0d: unit %0d, tag %0d, stalled %0d cycles, %s", k, unit, tag, stalls,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int count;
        int waited;
        clock        = 1'b0;
        reset        = 1'b0;
        id_valid     = 1'b0;
        id_use_b     = 1'b0;
        id_write_reg = 1'b0;
        id_op        = '0;
        id_funct     = '0;
        id_addr_a    = '0;
        id_addr_b    = '0;
        id_dest      = '0;
        cycle_count  = 0;
        checks       = 0;
        errors       = 0;
        wb_seen      = 0;
        wb_expected  = 0;
        outstanding  = 0;
        aborted      = 1'b0;
        for (int r = 0; r < 32; r++) begin
            pend_count[r] = 0;
            last_wb[r]    = -1;
            due_cycle[r]  = 0;
            exp_data[r]   = '0;
        end
        $readmemh("tests/issue_cases.txt", case_mem);

        for (int i = 0; i < 10; i++) begin
            next_cycle();
        end
        reset = 1'b1;
        next_cycle();
        check_value("iss_valid", iss_valid, 0);
        check_value("iss_alu", iss_alu, 0);
        check_value("iss_mem", iss_mem, 0);
        check_value("iss_mul", iss_mul, 0);
        check_value("wb_valid", wb_valid, 0);
        check_value("id_stall", id_stall, 0);
        $display("reset: %s", (errors == 0) ? "ok" : "failed");

        // A gap column of ff marks the end of the cases
        count = 0;
        while (!aborted && count < max_cases && case_mem[count * fields] != 32'hff) begin
            run_case(count);
            count++;
        end
        if (count == 0) begin
            report_failure("no cases were read from the cases file");
        end

        waited = 0;
        while (outstanding > 0 && waited < drain_wait) begin
            next_cycle();
            waited++;
        end
        if (outstanding > 0) begin
            report_failure($sformatf("%0d write-backs never arrived", outstanding));
        end
        for (int i = 0; i < 8; i++) begin
            next_cycle();
        end
        check_value("wb_count", wb_seen, wb_expected);

        $display("cases %0d, checks %0d, errors %0d", count, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/issue_cases.txt
// gap op funct a b dest use_b write_reg unit(0 alu 1 mem 2 mul) wb_data tag, all hex
// tag 0 no stall, 1 raw, 2 waw, 3 write-back slot conflict, gap ff ends the list
2 23 00 01 00 05 0 1 1 10000001 0
0 00 20 02 03 06 1 1 0 10000002 3
0 00 20 05 06 07 1 1 0 10000005 1
0 00 18 01 02 08 1 1 2 10000001 0
0 00 20 03 04 09 1 1 0 10000003 0
0 00 20 04 00 0a 0 1 0 10000004 0
0 00 20 01 00 0b 0 1 0 10000001 3
0 00 20 08 00 0c 0 1 0 10000008 1
0 23 00 03 00 0c 0 1 1 10000003 2
0 2b 00 02 0c 00 1 0 1 10000002 1
1 00 20 01 00 00 0 1 0 10000001 0
0 00 20 00 00 0d 1 1 0 10000000 0
0 00 18 05 06 0e 1 1 2 10000005 0
0 23 00 07 00 0f 0 1 1 10000007 0
0 00 20 02 00 10 0 1 0 10000002 3
0 00 20 0e 0f 11 1 1 0 1000000e 1
0 08 00 03 00 12 0 1 0 10000003 0
3 2b 00 01 02 00 1 0 1 10000001 0
0 23 18 04 00 13 0 1 1 10000004 0
ff 00 00 00 00 00 0 0 0 00000000 0

//--- filelist.f
design/issue_pkg.sv
design/unit_if.sv
design/scoreboard.sv
design/issue_stage.sv
design/unit_pipe.sv
design/writeback_arbiter.sv
design/issue_top.sv
tests/issue_props.sv
tests/issue_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module issue_tb \
    -f filelist.f -o issue_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/issue_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0
